/* src/seq_num_pkg.sv */
// -------------------------------------------------
// Sequence number unit shared definitions
// Width constants, entry lifecycle enum,
// commit and squash notification structs
// -------------------------------------------------

`default_nettype none

package seq_num_pkg;

  // -------------------------------------------------
  // Sizes
  // -------------------------------------------------

  // Width of one sequence number
  localparam int unsigned SEQ_BITS = 5;

  // One entry per number, so the space wraps cleanly
  localparam int unsigned NUM_SEQ = 2 ** SEQ_BITS;

  // Occupancy needs one extra bit to hold a full window
  localparam int unsigned CNT_BITS = SEQ_BITS + 1;

  // -------------------------------------------------
  // Entry lifecycle
  // -------------------------------------------------

  // FREE  -> available to the allocator
  // BUSY  -> handed out, not yet committed
  // DONE  -> committed, waiting for in-order reclaim
  typedef enum logic [1:0] {
    ENTRY_FREE = 2'd0,
    ENTRY_BUSY = 2'd1,
    ENTRY_DONE = 2'd2
  } entry_state_e;

  // -------------------------------------------------
  // Notification payloads
  // -------------------------------------------------

  // Commit from the back end
  // Only seq_num matters here; the rest rides along for other consumers
  typedef struct packed {
    logic [SEQ_BITS-1:0] seq_num;
    logic [31:0]         pc;
    logic [4:0]          waddr;
    logic [31:0]         wdata;
    logic                wen;
  } commit_msg_t;

  // Squash from a mispredicting instruction
  // Everything younger than seq_num is discarded
  typedef struct packed {
    logic [SEQ_BITS-1:0] seq_num;
    logic [31:0]         target;
  } squash_msg_t;

endpackage

`default_nettype wire

/* src/seq_alloc.sv */
// -------------------------------------------------
// Sequence number allocator
// Head pointer, occupancy counter, valid/ready
// handshake and squash rewind
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_alloc #(
  parameter int RECLAIM_WIDTH = 2
) (
  input  wire                                   clk,
  input  wire                                   rst_n,

  // Allocation port
  output logic                                  alloc_valid,
  input  wire                                   alloc_ready,
  output logic [seq_num_pkg::SEQ_BITS-1:0]      alloc_seq_num,

  // Towards the entry array
  output logic                                  alloc_fire,
  output logic [seq_num_pkg::SEQ_BITS-1:0]      head,

  // Squash notification
  input  wire                                   squash_valid,
  input  wire  seq_num_pkg::squash_msg_t        squash_msg,

  // From the reclaimer
  input  wire  [seq_num_pkg::SEQ_BITS-1:0]      tail,
  input  wire  [$clog2(RECLAIM_WIDTH+1)-1:0]    reclaim_count,

  // Occupancy
  output logic [seq_num_pkg::CNT_BITS-1:0]      in_flight
);

  // Full window, as an occupancy value
  localparam logic [seq_num_pkg::CNT_BITS-1:0] FULL =
    seq_num_pkg::CNT_BITS'(seq_num_pkg::NUM_SEQ);

  // -------------------------------------------------
  // Handshake
  // -------------------------------------------------

  // Window is contiguous from tail, so the head entry is free
  // whenever occupancy is below a full window
  assign alloc_valid   = (in_flight < FULL) && !squash_valid;
  assign alloc_fire    = alloc_valid && alloc_ready;
  assign alloc_seq_num = head;

  // -------------------------------------------------
  // Squash rewind
  // -------------------------------------------------

  // Age of the squashing number, counted from the oldest in flight
  logic [seq_num_pkg::SEQ_BITS-1:0] squash_age;

  // Reclaim run widened to the counter
  logic [seq_num_pkg::CNT_BITS-1:0] reclaim_cnt_ext;

  logic [seq_num_pkg::SEQ_BITS-1:0] head_next;
  logic [seq_num_pkg::CNT_BITS-1:0] in_flight_next;

  assign squash_age      = squash_msg.seq_num - tail;
  assign reclaim_cnt_ext = seq_num_pkg::CNT_BITS'(reclaim_count);

  always_comb begin
    head_next      = head;
    in_flight_next = in_flight;
    if (squash_valid) begin
      // Squashing number survives, everything after it goes
      head_next      = squash_msg.seq_num + 1'b1;
      // Survivors are tail..squash point, minus this cycle's reclaim
      in_flight_next = seq_num_pkg::CNT_BITS'(squash_age) + 1'b1 - reclaim_cnt_ext;
    end else begin
      // Wraps modulo NUM_SEQ by width
      head_next      = head + seq_num_pkg::SEQ_BITS'(alloc_fire);
      in_flight_next = in_flight + seq_num_pkg::CNT_BITS'(alloc_fire) - reclaim_cnt_ext;
    end
  end

  // -------------------------------------------------
  // State
  // -------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head      <= '0;
      in_flight <= '0;
    end else begin
      head      <= head_next;
      in_flight <= in_flight_next;
    end
  end

endmodule

`default_nettype wire

/* src/seq_entry.sv */
// -------------------------------------------------
// Per-number state tracker
// Free, busy and done lifecycle of one sequence number
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  wire                                clk,
  input  wire                                rst_n,

  // Allocation
  input  wire                                alloc_fire,
  input  wire  [seq_num_pkg::SEQ_BITS-1:0]   head,

  // Commit and squash notifications
  input  wire                                commit_valid,
  input  wire  seq_num_pkg::commit_msg_t     commit_msg,
  input  wire                                squash_valid,
  input  wire  seq_num_pkg::squash_msg_t     squash_msg,

  // Reclaim
  input  wire  [seq_num_pkg::SEQ_BITS-1:0]   tail,
  input  wire                                reclaim,

  output seq_num_pkg::entry_state_e          state
);

  // This entry's own number
  localparam logic [seq_num_pkg::SEQ_BITS-1:0] MY_IDX =
    seq_num_pkg::SEQ_BITS'(ENTRY_IDX);

  // Ages from the oldest in-flight number
  logic [seq_num_pkg::SEQ_BITS-1:0] my_age;
  logic [seq_num_pkg::SEQ_BITS-1:0] squash_age;

  logic alloc_hit;
  logic commit_hit;
  logic squash_hit;

  assign my_age     = MY_IDX - tail;
  assign squash_age = squash_msg.seq_num - tail;

  assign alloc_hit  = alloc_fire && (head == MY_IDX);
  assign commit_hit = commit_valid && (commit_msg.seq_num == MY_IDX);

  // Younger than the squash point and still holding a number
  assign squash_hit = squash_valid && (state != seq_num_pkg::ENTRY_FREE) &&
                      (my_age > squash_age);

  // Squash beats commit on the same entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= seq_num_pkg::ENTRY_FREE;
    end else if (squash_hit) begin
      state <= seq_num_pkg::ENTRY_FREE;
    end else if (reclaim) begin
      state <= seq_num_pkg::ENTRY_FREE;
    end else if (commit_hit && (state == seq_num_pkg::ENTRY_BUSY)) begin
      state <= seq_num_pkg::ENTRY_DONE;
    end else if (alloc_hit) begin
      state <= seq_num_pkg::ENTRY_BUSY;
    end
  end

endmodule

`default_nettype wire

/* src/seq_reclaim.sv */
// -------------------------------------------------
// In-order reclaimer
// Tail pointer and oldest-first scan freeing up to
// RECLAIM_WIDTH done entries per cycle
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_reclaim #(
  parameter int RECLAIM_WIDTH = 2
) (
  input  wire                                                 clk,
  input  wire                                                 rst_n,

  // Registered entry states, one per number
  input  seq_num_pkg::entry_state_e [seq_num_pkg::NUM_SEQ-1:0] states,

  // Oldest in-flight number
  output logic [seq_num_pkg::SEQ_BITS-1:0]                    tail,

  // Entries freed at the next edge
  output logic [seq_num_pkg::NUM_SEQ-1:0]                     reclaim_mask,
  output logic [$clog2(RECLAIM_WIDTH+1)-1:0]                  reclaim_count
);

  localparam int RC_BITS = $clog2(RECLAIM_WIDTH + 1);

  // -------------------------------------------------
  // Rotate by tail
  // -------------------------------------------------

  // Bit k is the done flag of the entry k places after tail
  logic [seq_num_pkg::NUM_SEQ-1:0] done_rot;

  always_comb begin
    for (int k = 0; k < seq_num_pkg::NUM_SEQ; k++) begin
      done_rot[k] = (states[seq_num_pkg::SEQ_BITS'(tail + k)] == seq_num_pkg::ENTRY_DONE);
    end
  end

  // -------------------------------------------------
  // Run scan
  // -------------------------------------------------

  // Leading run of done flags, capped at RECLAIM_WIDTH
  logic [RECLAIM_WIDTH-1:0] run_rot;
  logic [RC_BITS-1:0]       run_len;
  logic                     run_open;

  always_comb begin
    run_rot  = '0;
    run_len  = '0;
    run_open = 1'b1;
    for (int k = 0; k < RECLAIM_WIDTH; k++) begin
      // First busy or free entry closes the run
      if (run_open && done_rot[k]) begin
        run_rot[k] = 1'b1;
        run_len    = run_len + 1'b1;
      end else begin
        run_open = 1'b0;
      end
    end
  end

  // -------------------------------------------------
  // Rotate back to entry order
  // -------------------------------------------------

  always_comb begin
    reclaim_mask = '0;
    for (int k = 0; k < RECLAIM_WIDTH; k++) begin
      if (run_rot[k]) begin
        reclaim_mask[seq_num_pkg::SEQ_BITS'(tail + k)] = 1'b1;
      end
    end
  end

  assign reclaim_count = run_len;

  // -------------------------------------------------
  // Tail
  // -------------------------------------------------

  // Wraps modulo NUM_SEQ by width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail <= '0;
    end else begin
      tail <= tail + seq_num_pkg::SEQ_BITS'(run_len);
    end
  end

endmodule

`default_nettype wire

/* src/seq_num_gen.sv */
// -------------------------------------------------
// Sequence number unit top level
// Allocator, per-number entry array and reclaimer
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_num_gen #(
  parameter int RECLAIM_WIDTH = 2
) (
  input  wire                                clk,
  input  wire                                rst_n,

  // Allocation, valid/ready
  output logic                               alloc_valid,
  input  wire                                alloc_ready,
  output logic [seq_num_pkg::SEQ_BITS-1:0]   alloc_seq_num,

  // Commit notification, no back-pressure
  input  wire                                commit_valid,
  input  wire  seq_num_pkg::commit_msg_t     commit_msg,

  // Squash notification, no back-pressure
  input  wire                                squash_valid,
  input  wire  seq_num_pkg::squash_msg_t     squash_msg,

  // Numbers handed out and not yet reclaimed
  output logic [seq_num_pkg::CNT_BITS-1:0]   in_flight
);

  // -------------------------------------------------
  // Internal wiring
  // -------------------------------------------------

  logic                                                alloc_fire;
  logic [seq_num_pkg::SEQ_BITS-1:0]                    head;
  logic [seq_num_pkg::SEQ_BITS-1:0]                    tail;
  logic [seq_num_pkg::NUM_SEQ-1:0]                     reclaim_mask;
  logic [$clog2(RECLAIM_WIDTH+1)-1:0]                  reclaim_count;
  seq_num_pkg::entry_state_e [seq_num_pkg::NUM_SEQ-1:0] states;

  // Head side
  seq_alloc #(
    .RECLAIM_WIDTH (RECLAIM_WIDTH)
  ) i_seq_alloc (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_ready   (alloc_ready),
    .alloc_seq_num (alloc_seq_num),
    .alloc_fire    (alloc_fire),
    .head          (head),
    .squash_valid  (squash_valid),
    .squash_msg    (squash_msg),
    .tail          (tail),
    .reclaim_count (reclaim_count),
    .in_flight     (in_flight)
  );

  // One tracker per sequence number
  for (genvar i = 0; i < seq_num_pkg::NUM_SEQ; i++) begin : g_entry
    seq_entry #(
      .ENTRY_IDX (i)
    ) i_seq_entry (
      .clk          (clk),
      .rst_n        (rst_n),
      .alloc_fire   (alloc_fire),
      .head         (head),
      .commit_valid (commit_valid),
      .commit_msg   (commit_msg),
      .squash_valid (squash_valid),
      .squash_msg   (squash_msg),
      .tail         (tail),
      .reclaim      (reclaim_mask[i]),
      .state        (states[i])
    );
  end

  // Tail side
  seq_reclaim #(
    .RECLAIM_WIDTH (RECLAIM_WIDTH)
  ) i_seq_reclaim (
    .clk           (clk),
    .rst_n         (rst_n),
    .states        (states),
    .tail          (tail),
    .reclaim_mask  (reclaim_mask),
    .reclaim_count (reclaim_count)
  );

endmodule

`default_nettype wire

/* test/seq_num_gen_chk.sv */
// -------------------------------------------------
// Concurrent checks on the allocation handshake
// and the occupancy counter
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_num_gen_chk (
  input wire                              clk,
  input wire                              rst_n,
  input wire                              alloc_valid,
  input wire                              alloc_ready,
  input wire [seq_num_pkg::SEQ_BITS-1:0]  alloc_seq_num,
  input wire [seq_num_pkg::CNT_BITS-1:0]  in_flight
);

  // Full window as an occupancy value
  localparam logic [seq_num_pkg::CNT_BITS-1:0] FULL =
    seq_num_pkg::CNT_BITS'(seq_num_pkg::NUM_SEQ);

  // No offer once every number is out
  a_full_blocks_alloc: assert property (@(posedge clk) disable iff (!rst_n)
    (in_flight == FULL) |-> !alloc_valid
  ) else $error("alloc_valid high while the window is full");

  // Occupancy stays inside the number space
  a_in_flight_range: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= FULL
  ) else $error("in_flight above the number of sequence numbers");

  // Offered number holds under back-pressure
  a_offer_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(alloc_valid && !alloc_ready) |-> $stable(alloc_seq_num)
  ) else $error("alloc_seq_num changed while stalled");

endmodule

`default_nettype wire

/* test/seq_num_gen_tb.sv */
// -------------------------------------------------
// Testbench for the sequence number unit
// Clock, reset, LCG stimulus, in-order model,
// occupancy bounds, drain check and watchdog
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module seq_num_gen_tb;

  localparam int RECLAIM_WIDTH = 2;
  localparam int CLK_PERIOD    = 4;
  localparam int RAND_CYCLES   = 4000;
  // Reset, fill, stall and drain phases together stay well below this
  localparam int FIXED_CYCLES  = 400;
  localparam int NUM_SEQ       = seq_num_pkg::NUM_SEQ;

  // One in-flight number as the model sees it
  typedef struct packed {
    logic [seq_num_pkg::SEQ_BITS-1:0] num;
    logic                             done;
  } model_entry_t;

  logic                             clk;
  logic                             rst_n;
  logic                             alloc_valid;
  logic                             alloc_ready;
  logic [seq_num_pkg::SEQ_BITS-1:0] alloc_seq_num;
  logic                             commit_valid;
  seq_num_pkg::commit_msg_t         commit_msg;
  logic                             squash_valid;
  seq_num_pkg::squash_msg_t         squash_msg;
  logic [seq_num_pkg::CNT_BITS-1:0] in_flight;

  // Oldest first, front lines up with the DUT tail
  model_entry_t                     model_q[$];
  logic [seq_num_pkg::SEQ_BITS-1:0] next_num;
  logic [31:0]                      rng_state;

  seq_num_gen #(
    .RECLAIM_WIDTH (RECLAIM_WIDTH)
  ) i_seq_num_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_ready   (alloc_ready),
    .alloc_seq_num (alloc_seq_num),
    .commit_valid  (commit_valid),
    .commit_msg    (commit_msg),
    .squash_valid  (squash_valid),
    .squash_msg    (squash_msg),
    .in_flight     (in_flight)
  );

  bind seq_num_gen seq_num_gen_chk i_seq_num_gen_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_ready   (alloc_ready),
    .alloc_seq_num (alloc_seq_num),
    .in_flight     (in_flight)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // -------------------------------------------------
  // Helpers
  // -------------------------------------------------

  // LCG step, upper half used as the random value
  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 16) % n;
  endfunction

  task automatic check_eq(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%0t %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "%s", msg);
  endtask

  // Oldest number not yet committed, -1 if none
  function automatic int first_busy_pos();
    for (int i = 0; i < model_q.size(); i++) begin
      if (!model_q[i].done) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic int pick_busy();
    int busy[$];
    for (int i = 0; i < model_q.size(); i++) begin
      if (!model_q[i].done) begin
        busy.push_back(i);
      end
    end
    if (busy.size() == 0) begin
      return -1;
    end
    return busy[rand_below(busy.size())];
  endfunction

  // In_flight sits between the entries the reclaimer cannot pass and all of them
  task automatic check_occupancy();
    int hi;
    int lo;
    int fb;
    int got;
    int exp;
    hi  = model_q.size();
    fb  = first_busy_pos();
    lo  = (fb < 0) ? 0 : hi - fb;
    got = int'(in_flight);
    exp = got;
    if (got < lo) begin
      exp = lo;
    end
    if (got > hi) begin
      exp = hi;
    end
    check_eq("in_flight", got, exp);
    // Drop what the DUT reclaimed, oldest first
    while (model_q.size() > got) begin
      void'(model_q.pop_front());
    end
  endtask

  // One clock: drive at the falling edge, predict the rising edge, check after it
  task automatic run_cycle(input logic ready, input int commit_pos, input int squash_pos);
    seq_num_pkg::commit_msg_t cm;
    seq_num_pkg::squash_msg_t sm;
    model_entry_t             ent;
    logic                     exp_valid;
    logic                     fire;
    cm = '0;
    sm = '0;
    if (commit_pos >= 0) begin
      cm.seq_num = model_q[commit_pos].num;
      cm.pc      = rand_below(65536) << 2;
      cm.waddr   = 5'(rand_below(32));
      cm.wdata   = rand_below(65536);
      cm.wen     = (rand_below(2) != 0);
    end
    if (squash_pos >= 0) begin
      sm.seq_num = model_q[squash_pos].num;
      sm.target  = rand_below(65536) << 2;
    end
    alloc_ready  = ready;
    commit_valid = (commit_pos >= 0);
    commit_msg   = cm;
    squash_valid = (squash_pos >= 0);
    squash_msg   = sm;
    #1;
    exp_valid = (model_q.size() < NUM_SEQ) && (squash_pos < 0);
    check_eq("alloc_valid", int'(alloc_valid), int'(exp_valid));
    if (alloc_valid) begin
      check_eq("alloc_seq_num", int'(alloc_seq_num), int'(next_num));
    end
    fire = alloc_valid && alloc_ready;
    if (squash_pos >= 0) begin
      // Squash point survives, younger numbers go
      next_num = model_q[squash_pos].num + 1'b1;
      while (model_q.size() > squash_pos + 1) begin
        void'(model_q.pop_back());
      end
    end else begin
      if (commit_pos >= 0) begin
        ent               = model_q[commit_pos];
        ent.done          = 1'b1;
        model_q[commit_pos] = ent;
      end
      if (fire) begin
        ent.num  = next_num;
        ent.done = 1'b0;
        model_q.push_back(ent);
        next_num = next_num + 1'b1;
      end
    end
    @(negedge clk);
    check_occupancy();
  endtask

  // -------------------------------------------------
  // Stimulus
  // -------------------------------------------------

  initial begin
    int   n;
    int   pos;
    int   commit_pos;
    int   squash_pos;
    logic ready;
    rst_n        = 1'b0;
    alloc_ready  = 1'b0;
    commit_valid = 1'b0;
    commit_msg   = '0;
    squash_valid = 1'b0;
    squash_msg   = '0;
    rng_state    = 32'h8165;
    next_num     = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_occupancy();

    // Fill the whole window, then stall on it
    for (int i = 0; i < NUM_SEQ; i++) begin
      run_cycle(1'b1, -1, -1);
    end
    repeat (8) run_cycle(1'b1, -1, -1);
    // Free the oldest, window must open again
    run_cycle(1'b0, 0, -1);
    n = 0;
    while (int'(in_flight) == NUM_SEQ) begin
      if (n == 8) begin
        fail_run("window stayed full after the oldest number was committed");
      end
      run_cycle(1'b0, -1, -1);
      n++;
    end

    // Random mix of allocation, commit and squash
    for (int c = 0; c < RAND_CYCLES; c++) begin
      ready      = (rand_below(4) != 0);
      commit_pos = -1;
      squash_pos = -1;
      if (rand_below(24) == 0) begin
        squash_pos = pick_busy();
      end else if (rand_below(3) != 0) begin
        commit_pos = pick_busy();
      end
      run_cycle(ready, commit_pos, squash_pos);
    end

    // Drain: commit every busy number with allocation stopped
    pos = first_busy_pos();
    while (pos >= 0) begin
      run_cycle(1'b0, pos, -1);
      pos = first_busy_pos();
    end
    n = 0;
    while (int'(in_flight) != 0) begin
      if (n == NUM_SEQ) begin
        fail_run("in_flight did not reach zero after all numbers were committed");
      end
      run_cycle(1'b0, -1, -1);
      n++;
    end

    $display("Test OK");
    $finish;
  end

  // Watchdog sized from the random phase plus the directed phases
  initial begin
    #((RAND_CYCLES + FIXED_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* sources.f */
src/seq_num_pkg.sv
src/seq_alloc.sv
src/seq_entry.sv
src/seq_reclaim.sv
src/seq_num_gen.sv
test/seq_num_gen_chk.sv
test/seq_num_gen_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the sequence number unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module seq_num_gen_tb \
  -o sim_seq_num_gen

out="$(./obj_dir/sim_seq_num_gen 2>&1 || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
